// ==== verilog/cache_axi_pkg.sv ====
`default_nettype none

package cache_axi_pkg;

    localparam int ADDR_W = 32;
    localparam int LINE_W = 128;
    localparam int STRB_W = LINE_W / 8;  // One strobe per byte
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [2:0]        size_t;   // log2 of byte count, as AXI size
    typedef logic [1:0]        burst_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [1:0]        resp_t;
    typedef logic [ID_W-1:0]   axi_id_t;

    localparam size_t   SIZE_LINE    = 3'd4;   // 16 bytes
    localparam burst_t  BURST_INCR   = 2'b01;
    localparam len_t    LEN_ONE      = 8'd0;   // Single beat
    localparam axi_id_t ICACHE_ID    = 4'd0;
    localparam axi_id_t DCACHE_ID    = 4'd1;
    localparam axi_id_t DCACHE_WR_ID = 4'd1;

    // Client side payloads
    typedef struct packed {
        addr_t addr;
        size_t size;
    } rd_req_t;

    typedef struct packed {
        addr_t addr;
        strb_t strb;
        line_t data;
    } wr_req_t;

    // AXI channels
    typedef struct packed {
        axi_id_t id;
        addr_t   addr;
        len_t    len;
        size_t   size;
        burst_t  burst;
    } axi_ar_t;

    typedef struct packed {
        axi_id_t id;
        line_t   data;
        resp_t   resp;
        logic    last;
    } axi_r_t;

    typedef struct packed {
        axi_id_t id;
        addr_t   addr;
        len_t    len;
        size_t   size;
        burst_t  burst;
    } axi_aw_t;

    typedef struct packed {
        line_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t id;
        resp_t   resp;
    } axi_b_t;

endpackage

`default_nettype wire

// ==== verilog/axi_read_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_read_arbiter
    import cache_axi_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,

    // Instruction cache
    input  logic    icache_req_valid_i,
    input  addr_t   icache_req_addr_i,
    output logic    icache_req_ready_o,
    output logic    icache_resp_valid_o,
    output line_t   icache_resp_data_o,
    input  logic    icache_resp_ready_i,

    // Data cache
    input  logic    dcache_req_valid_i,
    input  rd_req_t dcache_req_i,
    output logic    dcache_req_ready_o,
    output logic    dcache_resp_valid_o,
    output line_t   dcache_resp_data_o,
    input  logic    dcache_resp_ready_i,

    input  logic    wr_busy_i,       // Write side still waiting on B

    // AXI read address
    output axi_ar_t ar_o,
    output logic    arvalid_o,
    input  logic    arready_i,

    // AXI read data
    input  axi_r_t  r_i,
    input  logic    rvalid_i,
    output logic    rready_o
);

    typedef enum logic {
        AR_IDLE,
        AR_SEND
    } ar_state_e;

    ar_state_e state_q;
    axi_ar_t   ar_q;
    logic      ic_pend_q;            // ICache read in flight
    logic      dc_pend_q;            // DCache read in flight
    logic      ar_idle;
    logic      dc_take;
    logic      ic_take;
    logic      r_is_ic;
    logic      r_is_dc;
    logic      ic_done;
    logic      dc_done;

    assign ar_idle = (state_q == AR_IDLE);

    // Data reads are held while a write is open, keeps read-after-write order
    assign dcache_req_ready_o = ar_idle && !dc_pend_q && !wr_busy_i;
    assign dc_take            = dcache_req_valid_i && dcache_req_ready_o;

    // DCache wins a tie
    assign icache_req_ready_o = ar_idle && !ic_pend_q && !dc_take;
    assign ic_take            = icache_req_valid_i && icache_req_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= AR_IDLE;
        end else begin
            case (state_q)
                AR_IDLE: begin
                    if (dc_take || ic_take) begin
                        state_q <= AR_SEND;
                    end
                end
                AR_SEND: begin
                    if (arready_i) begin
                        state_q <= AR_IDLE;
                    end
                end
                default: state_q <= AR_IDLE;
            endcase
        end
    end

    // Latch the winner into the AR beat
    always_ff @(posedge clk) begin
        if (dc_take) begin
            ar_q <= '{id:    DCACHE_ID,
                      addr:  dcache_req_i.addr,
                      len:   LEN_ONE,
                      size:  dcache_req_i.size,
                      burst: BURST_INCR};
        end else if (ic_take) begin
            ar_q <= '{id:    ICACHE_ID,
                      addr:  icache_req_addr_i,
                      len:   LEN_ONE,
                      size:  SIZE_LINE,       // Always a full line
                      burst: BURST_INCR};
        end
    end

    assign ar_o      = ar_q;
    assign arvalid_o = (state_q == AR_SEND);

    // One read per ID in flight
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ic_pend_q <= 1'b0;
            dc_pend_q <= 1'b0;
        end else begin
            if (ic_take) begin
                ic_pend_q <= 1'b1;
            end else if (ic_done) begin
                ic_pend_q <= 1'b0;
            end
            if (dc_take) begin
                dc_pend_q <= 1'b1;
            end else if (dc_done) begin
                dc_pend_q <= 1'b0;
            end
        end
    end

    // Responses steered by R id, may arrive in either order
    assign r_is_ic = (r_i.id == ICACHE_ID);
    assign r_is_dc = (r_i.id == DCACHE_ID);

    assign icache_resp_valid_o = rvalid_i && r_is_ic;
    assign icache_resp_data_o  = r_i.data;
    assign dcache_resp_valid_o = rvalid_i && r_is_dc;
    assign dcache_resp_data_o  = r_i.data;   // Client picks its bytes

    // Client back-pressure stalls R
    assign rready_o = (r_is_ic && icache_resp_ready_i) || (r_is_dc && dcache_resp_ready_i);

    assign ic_done = icache_resp_valid_o && icache_resp_ready_i;
    assign dc_done = dcache_resp_valid_o && dcache_resp_ready_i;

endmodule

`default_nettype wire

// ==== verilog/axi_write_channel.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_write_channel
    import cache_axi_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,

    // Data cache line write
    input  logic    dcache_wr_valid_i,
    input  wr_req_t dcache_wr_i,
    output logic    dcache_wr_ready_o,

    output logic    wr_busy_o,          // To read side

    // AXI write address
    output axi_aw_t aw_o,
    output logic    awvalid_o,
    input  logic    awready_i,

    // AXI write data
    output axi_w_t  w_o,
    output logic    wvalid_o,
    input  logic    wready_i,

    // AXI write response
    input  axi_b_t  b_i,
    input  logic    bvalid_i,
    output logic    bready_o
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SEND,
        WR_RESP
    } wr_state_e;

    wr_state_e state_q;
    axi_aw_t   aw_q;
    axi_w_t    w_q;
    logic      aw_done_q;
    logic      w_done_q;
    logic      wr_take;
    logic      aw_fin;
    logic      w_fin;
    logic      b_hs;

    assign dcache_wr_ready_o = (state_q == WR_IDLE);
    assign wr_take           = dcache_wr_valid_i && dcache_wr_ready_o;

    // Busy from acceptance through the B handshake cycle
    assign wr_busy_o = (state_q != WR_IDLE) || wr_take;

    // AW and W complete independently
    assign awvalid_o = (state_q == WR_SEND) && !aw_done_q;
    assign wvalid_o  = (state_q == WR_SEND) && !w_done_q;
    assign aw_fin    = aw_done_q || (awvalid_o && awready_i);
    assign w_fin     = w_done_q || (wvalid_o && wready_i);

    assign bready_o = (state_q == WR_RESP);
    // Stray IDs are dropped
    assign b_hs     = bvalid_i && bready_o && (b_i.id == DCACHE_WR_ID);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= WR_IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            case (state_q)
                WR_IDLE: begin
                    aw_done_q <= 1'b0;
                    w_done_q  <= 1'b0;
                    if (wr_take) begin
                        state_q <= WR_SEND;
                    end
                end
                WR_SEND: begin
                    aw_done_q <= aw_fin;
                    w_done_q  <= w_fin;
                    if (aw_fin && w_fin) begin
                        state_q <= WR_RESP;   // Both sent, wait for B
                    end
                end
                WR_RESP: begin
                    if (b_hs) begin
                        state_q <= WR_IDLE;
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            aw_q <= '{id:    DCACHE_WR_ID,
                      addr:  dcache_wr_i.addr,
                      len:   LEN_ONE,
                      size:  SIZE_LINE,
                      burst: BURST_INCR};
            w_q  <= '{data: dcache_wr_i.data,
                      strb: dcache_wr_i.strb,
                      last: 1'b1};
        end
    end

    assign aw_o = aw_q;
    assign w_o  = w_q;

endmodule

`default_nettype wire

// ==== verilog/cache_axi_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_axi_bridge
    import cache_axi_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,

    // Instruction cache read
    input  logic    icache_req_valid_i,
    input  addr_t   icache_req_addr_i,
    output logic    icache_req_ready_o,
    output logic    icache_resp_valid_o,
    output line_t   icache_resp_data_o,
    input  logic    icache_resp_ready_i,

    // Data cache read
    input  logic    dcache_req_valid_i,
    input  rd_req_t dcache_req_i,
    output logic    dcache_req_ready_o,
    output logic    dcache_resp_valid_o,
    output line_t   dcache_resp_data_o,
    input  logic    dcache_resp_ready_i,

    // Data cache write
    input  logic    dcache_wr_valid_i,
    input  wr_req_t dcache_wr_i,
    output logic    dcache_wr_ready_o,

    // AXI master port
    output axi_ar_t ar_o,
    output logic    arvalid_o,
    input  logic    arready_i,
    input  axi_r_t  r_i,
    input  logic    rvalid_i,
    output logic    rready_o,
    output axi_aw_t aw_o,
    output logic    awvalid_o,
    input  logic    awready_i,
    output axi_w_t  w_o,
    output logic    wvalid_o,
    input  logic    wready_i,
    input  axi_b_t  b_i,
    input  logic    bvalid_i,
    output logic    bready_o
);

    logic wr_busy;   // Holds data reads behind an open write

    axi_read_arbiter u_read_arbiter (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .icache_req_valid_i  (icache_req_valid_i),
        .icache_req_addr_i   (icache_req_addr_i),
        .icache_req_ready_o  (icache_req_ready_o),
        .icache_resp_valid_o (icache_resp_valid_o),
        .icache_resp_data_o  (icache_resp_data_o),
        .icache_resp_ready_i (icache_resp_ready_i),
        .dcache_req_valid_i  (dcache_req_valid_i),
        .dcache_req_i        (dcache_req_i),
        .dcache_req_ready_o  (dcache_req_ready_o),
        .dcache_resp_valid_o (dcache_resp_valid_o),
        .dcache_resp_data_o  (dcache_resp_data_o),
        .dcache_resp_ready_i (dcache_resp_ready_i),
        .wr_busy_i           (wr_busy),
        .ar_o                (ar_o),
        .arvalid_o           (arvalid_o),
        .arready_i           (arready_i),
        .r_i                 (r_i),
        .rvalid_i            (rvalid_i),
        .rready_o            (rready_o)
    );

    axi_write_channel u_write_channel (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .dcache_wr_valid_i (dcache_wr_valid_i),
        .dcache_wr_i       (dcache_wr_i),
        .dcache_wr_ready_o (dcache_wr_ready_o),
        .wr_busy_o         (wr_busy),
        .aw_o              (aw_o),
        .awvalid_o         (awvalid_o),
        .awready_i         (awready_i),
        .w_o               (w_o),
        .wvalid_o          (wvalid_o),
        .wready_i          (wready_i),
        .b_i               (b_i),
        .bvalid_i          (bvalid_i),
        .bready_o          (bready_o)
    );

endmodule

`default_nettype wire

// ==== sim/cache_axi_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_axi_checker
    import cache_axi_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  axi_ar_t ar_i,
    input  logic    arvalid_i,
    input  logic    arready_i,
    input  axi_aw_t aw_i,
    input  logic    awvalid_i,
    input  logic    awready_i,
    input  axi_w_t  w_i,
    input  logic    wvalid_i,
    input  logic    wready_i
);

    // Valid holds with a stable payload until ready
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
        else $error("AR dropped or changed before arready");

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        awvalid_i && !awready_i |=> awvalid_i && $stable(aw_i))
        else $error("AW dropped or changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        wvalid_i && !wready_i |=> wvalid_i && $stable(w_i))
        else $error("W dropped or changed before wready");

    // Registered valids are low out of reset
    rst_quiet: assert property (@(posedge clk)
        !rst_n_i |=> !arvalid_i && !awvalid_i && !wvalid_i)
        else $error("Valid raised during reset");

endmodule

`default_nettype wire

// ==== sim/cache_axi_bridge_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_axi_bridge_tb
    import cache_axi_pkg::*;
();

    localparam int    CLK_P = 4;
    localparam int    N_TX  = 34;              // Transactions issued over all tests
    localparam addr_t BASE  = 32'h1c00_0000;   // Bits 9:4 clear, line index below

    logic    clk;
    logic    rst_n_i;
    logic    icache_req_valid_i, icache_req_ready_o;
    addr_t   icache_req_addr_i;
    logic    icache_resp_valid_o, icache_resp_ready_i;
    line_t   icache_resp_data_o;
    logic    dcache_req_valid_i, dcache_req_ready_o;
    rd_req_t dcache_req_i;
    logic    dcache_resp_valid_o, dcache_resp_ready_i;
    line_t   dcache_resp_data_o;
    logic    dcache_wr_valid_i, dcache_wr_ready_o;
    wr_req_t dcache_wr_i;
    axi_ar_t ar;
    axi_r_t  r;
    axi_aw_t aw;
    axi_w_t  w;
    axi_b_t  b;
    logic    arvalid, arready, rvalid, rready;
    logic    awvalid, awready, wvalid, wready, bvalid, bready;

    logic [31:0] lfsr;
    line_t       mem [64];       // Slave memory
    line_t       exp_mem [64];   // Shadow copy for the reference
    line_t       ic_exp_q[$];
    line_t       dc_exp_q[$];
    size_t       dc_size_q[$];
    int          err_cnt;
    int          chk_cnt;
    logic        rand_ready;     // Random client back-pressure
    logic        pair_hold;      // Slave waits for both reads
    logic        ic_first;
    logic        write_open;
    logic        rd_pend [2];
    addr_t       rd_addr [2];
    logic        r_on, b_on, aw_got, w_got;
    axi_aw_t     aw_s;
    axi_w_t      w_s;

    cache_axi_bridge cache_axi_bridge_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .icache_req_valid_i(icache_req_valid_i), .icache_req_addr_i(icache_req_addr_i),
        .icache_req_ready_o(icache_req_ready_o), .icache_resp_valid_o(icache_resp_valid_o),
        .icache_resp_data_o(icache_resp_data_o), .icache_resp_ready_i(icache_resp_ready_i),
        .dcache_req_valid_i(dcache_req_valid_i), .dcache_req_i(dcache_req_i),
        .dcache_req_ready_o(dcache_req_ready_o), .dcache_resp_valid_o(dcache_resp_valid_o),
        .dcache_resp_data_o(dcache_resp_data_o), .dcache_resp_ready_i(dcache_resp_ready_i),
        .dcache_wr_valid_i(dcache_wr_valid_i), .dcache_wr_i(dcache_wr_i),
        .dcache_wr_ready_o(dcache_wr_ready_o),
        .ar_o(ar), .arvalid_o(arvalid), .arready_i(arready),
        .r_i(r), .rvalid_i(rvalid), .rready_o(rready),
        .aw_o(aw), .awvalid_o(awvalid), .awready_i(awready),
        .w_o(w), .wvalid_o(wvalid), .wready_i(wready),
        .b_i(b), .bvalid_i(bvalid), .bready_o(bready)
    );

    bind cache_axi_bridge cache_axi_checker u_checker (
        .clk(clk), .rst_n_i(rst_n_i),
        .ar_i(ar_o), .arvalid_i(arvalid_o), .arready_i(arready_i),
        .aw_i(aw_o), .awvalid_i(awvalid_o), .awready_i(awready_i),
        .w_i(w_o), .wvalid_i(wvalid_o), .wready_i(wready_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_P / 2) clk = ~clk;
    end

    // Galois LFSR, one step per bit
    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function logic rand_bit();
        logic [31:0] v;
        v = rand_bits(1);
        return v[0];
    endfunction

    function automatic line_t line_init(input addr_t a);
        addr_t la;
        line_t l;
        la = {a[31:4], 4'h0};
        for (int i = 0; i < 4; i++) begin
            l[32*i +: 32] = la ^ 32'(i);   // Word index folded in
        end
        return l;
    endfunction

    function automatic line_t merge_line(input line_t old, input line_t d, input strb_t s);
        for (int i = 0; i < STRB_W; i++) begin
            if (s[i]) old[8*i +: 8] = d[8*i +: 8];
        end
        return old;
    endfunction

    function line_t expected_line(input addr_t a);
        return exp_mem[a[9:4]];
    endfunction

    function addr_t line_addr(input logic [5:0] idx);
        return BASE | {22'h0, idx, 4'h0};
    endfunction

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        chk_cnt++;
        assert (got === exp) else begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic icache_read(input addr_t a);
        icache_req_addr_i  = a;
        icache_req_valid_i = 1'b1;
        do @(posedge clk); while (!icache_req_ready_o);
        ic_exp_q.push_back(expected_line(a));
        #1 icache_req_valid_i = 1'b0;
    endtask

    task automatic dcache_read(input addr_t a, input size_t s);
        dcache_req_i       = '{addr: a, size: s};
        dcache_req_valid_i = 1'b1;
        do @(posedge clk); while (!dcache_req_ready_o);
        dc_exp_q.push_back(expected_line(a));
        dc_size_q.push_back(s);
        #1 dcache_req_valid_i = 1'b0;
    endtask

    task automatic dcache_write(input addr_t a, input strb_t s, input line_t d);
        dcache_wr_i       = '{addr: a, strb: s, data: d};
        dcache_wr_valid_i = 1'b1;
        do @(posedge clk); while (!dcache_wr_ready_o);
        exp_mem[a[9:4]] = merge_line(exp_mem[a[9:4]], d, s);
        #1 dcache_wr_valid_i = 1'b0;
    endtask

    task automatic wait_done();
        do begin
            @(posedge clk);
            #1;
        end while (ic_exp_q.size() != 0 || dc_exp_q.size() != 0 || !dcache_wr_ready_o);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %-22s %s", name, (err_cnt == errs_before) ? "ok" : "FAIL");
    endtask

    // Slave model, samples at the edge and drives 1 ns later
    initial begin
        logic sel;
        forever begin
            @(posedge clk);
            if (arvalid && arready) begin
                check_val("ar_o.len", 128'(ar.len), 128'(LEN_ONE));
                check_val("ar_o.burst", 128'(ar.burst), 128'(BURST_INCR));
                if (ar.id == ICACHE_ID) begin
                    check_val("ar_o.size", 128'(ar.size), 128'(SIZE_LINE));
                end else if (ar.id == DCACHE_ID && dc_size_q.size() != 0) begin
                    check_val("ar_o.size", 128'(ar.size), 128'(dc_size_q.pop_front()));
                end else begin
                    $display("AR carried an unexpected id %h", ar.id);
                    err_cnt++;
                end
                rd_pend[ar.id[0]] = 1'b1;
                rd_addr[ar.id[0]] = ar.addr;
            end
            if (rvalid && rready) begin
                rd_pend[r.id[0]] = 1'b0;
                r_on             = 1'b0;
            end
            if (awvalid && awready) begin
                check_val("aw_o.id", 128'(aw.id), 128'(DCACHE_WR_ID));
                check_val("aw_o.len", 128'(aw.len), 128'(LEN_ONE));
                check_val("aw_o.size", 128'(aw.size), 128'(SIZE_LINE));
                check_val("aw_o.burst", 128'(aw.burst), 128'(BURST_INCR));
                aw_s   = aw;
                aw_got = 1'b1;
            end
            if (wvalid && wready) begin
                check_val("w_o.last", 128'(w.last), 128'(1'b1));   // Single beat
                w_s   = w;
                w_got = 1'b1;
            end
            if (bvalid && bready) b_on = 1'b0;
            #1;
            arready = rand_bit();
            awready = rand_bit();
            wready  = rand_bit();
            icache_resp_ready_i = rand_ready ? rand_bit() : 1'b1;
            dcache_resp_ready_i = rand_ready ? rand_bit() : 1'b1;
            if (!r_on && (rd_pend[0] || rd_pend[1])) begin
                if (rd_pend[0] && rd_pend[1]) begin
                    sel       = pair_hold ? !ic_first : rand_bit();
                    pair_hold = 1'b0;
                    r_on      = 1'b1;
                end else if (!pair_hold && rand_bit()) begin
                    sel  = rd_pend[1];
                    r_on = 1'b1;
                end
                if (r_on) begin
                    r = '{id: sel ? DCACHE_ID : ICACHE_ID, data: mem[rd_addr[sel][9:4]],
                          resp: 2'b00, last: 1'b1};
                end
            end
            if (aw_got && w_got && !b_on && rand_bit()) begin
                mem[aw_s.addr[9:4]] = merge_line(mem[aw_s.addr[9:4]], w_s.data, w_s.strb);
                b      = '{id: DCACHE_WR_ID, resp: 2'b00};
                b_on   = 1'b1;
                aw_got = 1'b0;
                w_got  = 1'b0;
            end
            rvalid = r_on;
            bvalid = b_on;
        end
    end

    // Compare process
    always @(posedge clk) begin
        if (rst_n_i) begin
            if (dcache_wr_valid_i && dcache_wr_ready_o) write_open = 1'b1;
            if (dcache_req_valid_i && dcache_req_ready_o) begin
                chk_cnt++;
                assert (!write_open) else begin
                    $display("Data read accepted before the open write got its response");
                    err_cnt++;
                end
            end
            if (bvalid && bready) write_open = 1'b0;
            if (rvalid) begin
                check_val("rready_o", 128'(rready),
                          128'((r.id == ICACHE_ID) ? icache_resp_ready_i
                                                   : dcache_resp_ready_i));
            end
            if (icache_resp_valid_o && icache_resp_ready_i) begin
                if (ic_exp_q.size() == 0) begin
                    $display("Instruction response arrived with no read open");
                    err_cnt++;
                end else begin
                    check_val("icache_resp_data_o", icache_resp_data_o, ic_exp_q.pop_front());
                end
            end
            if (dcache_resp_valid_o && dcache_resp_ready_i) begin
                if (dc_exp_q.size() == 0) begin
                    $display("Data response arrived with no read open");
                    err_cnt++;
                end else begin
                    check_val("dcache_resp_data_o", dcache_resp_data_o, dc_exp_q.pop_front());
                end
            end
        end
    end

    initial begin
        #(N_TX * 200 * CLK_P);
        $display("Timeout, transactions did not finish in time");
        $display("tests failed");
        $finish;
    end

    initial begin
        int    e0;
        addr_t a;
        size_t sizes [4];
        sizes = '{3'd0, 3'd1, 3'd2, SIZE_LINE};
        lfsr = 32'h8b96;
        err_cnt = 0;
        chk_cnt = 0;
        {icache_req_valid_i, dcache_req_valid_i, dcache_wr_valid_i} = '0;
        icache_req_addr_i = '0;
        dcache_req_i = '0;
        dcache_wr_i = '0;
        {icache_resp_ready_i, dcache_resp_ready_i} = 2'b11;
        {arready, awready, wready, rvalid, bvalid} = '0;
        r = '0;
        b = '0;
        {rand_ready, pair_hold, ic_first, write_open} = '0;
        {r_on, b_on, aw_got, w_got} = '0;
        rd_pend = '{1'b0, 1'b0};
        for (int i = 0; i < 64; i++) begin
            mem[i]     = line_init(line_addr(6'(i)));
            exp_mem[i] = mem[i];
        end
        rst_n_i = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n_i = 1'b1;

        e0 = err_cnt;
        for (int k = 0; k < 4; k++) icache_read(line_addr(6'(rand_bits(6))));
        wait_done();
        report_test("icache line read", e0);

        e0 = err_cnt;
        for (int k = 0; k < 4; k++) begin
            dcache_read(line_addr(6'(rand_bits(6))) | addr_t'(k * 4), sizes[k]);
        end
        wait_done();
        report_test("dcache sized read", e0);

        e0 = err_cnt;
        for (int k = 0; k < 3; k++) begin
            a = line_addr(6'(rand_bits(6)));
            dcache_write(a, strb_t'(rand_bits(16)),
                         {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)});
            dcache_read(a, SIZE_LINE);
            wait_done();
        end
        report_test("write then read", e0);

        e0 = err_cnt;
        for (int k = 0; k < 4; k++) begin
            pair_hold = 1'b1;
            ic_first  = k[0];    // Alternate return order
            fork
                icache_read(line_addr(6'(rand_bits(6))));
                dcache_read(line_addr(6'(rand_bits(6))), SIZE_LINE);
            join
            wait_done();
        end
        report_test("parallel reads", e0);

        e0 = err_cnt;
        rand_ready = 1'b1;
        for (int k = 0; k < 4; k++) begin
            fork
                icache_read(line_addr(6'(rand_bits(6))));
                dcache_read(line_addr(6'(rand_bits(6))), size_t'(rand_bits(2)));
            join
        end
        wait_done();
        rand_ready = 1'b0;
        report_test("client back-pressure", e0);

        e0 = err_cnt;
        for (int k = 0; k < 2; k++) begin
            a = line_addr(6'(rand_bits(6)));
            dcache_write(a, strb_t'(rand_bits(16)),
                         {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)});
            dcache_read(a, SIZE_LINE);   // Presented while the write is open
            wait_done();
        end
        report_test("read behind write", e0);

        $display("%0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cache_axi_bridge.f ====
verilog/cache_axi_pkg.sv
verilog/axi_read_arbiter.sv
verilog/axi_write_channel.sv
verilog/cache_axi_bridge.sv
sim/cache_axi_checker.sv
sim/cache_axi_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module cache_axi_bridge_tb \
    -f cache_axi_bridge.f
if [ $? -ne 0 ]; then
    echo "Compile error"
    exit 1
fi

./obj_dir/Vcache_axi_bridge_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    exit 1
fi
exit 0
